// File: rtl/bbc_mem_pkg.sv
package bbc_mem_pkg;

// CPU side of the host bus
typedef logic [15:0] cpu_addr_t;
typedef logic [7:0]  cpu_data_t;

// Access control register flags, bit 7 down to bit 0
typedef struct packed {
	logic irr;
	logic tst;
	logic ifj;
	logic itu;
	logic y;
	logic x;
	logic e;
	logic d;
} acccon_bits_t;

// Same byte seen as bus data or as individual control flags
typedef union packed {
	cpu_data_t    raw;
	acccon_bits_t flags;
} acccon_u;

// SHEILA registers kept in this block
localparam cpu_addr_t ROMSEL_ADDR = 16'hFE30;
localparam cpu_addr_t ACCCON_ADDR = 16'hFE34;

// VDU driver code lives in 0xC000-0xDFFF
localparam logic [2:0] VDU_PAGE = 3'b110;

// Shadow window 0x3000-0x7FFF
// 0x3000-0x3FFF by nibble, 0x4000-0x7FFF by quarter
localparam logic [3:0] SHADOW_LO_PAGE    = 4'h3;
localparam logic [1:0] SHADOW_HI_QUARTER = 2'b01;

endpackage

// File: rtl/bbc_video_pkg.sv
package bbc_video_pkg;

// CRTC refresh address and the row bits needed for bitmap modes
typedef logic [13:0] crtc_ma_t;
typedef logic [2:0]  crtc_ra_t;

// Address into the 32K display RAM
typedef logic [14:0] disp_addr_t;

// Wrap selector from IC32 bits 5..4
typedef logic [1:0] disp_offs_t;

// Page offsets added when the CRTC runs past 0x8000
// Mode 3 restarts at 0x4000
localparam logic [3:0] WRAP_MODE3   = 4'd8;
// Mode 6 restarts at 0x6000
localparam logic [3:0] WRAP_MODE6   = 4'd12;
// Modes 0, 1 and 2 restart at 0x3000
localparam logic [3:0] WRAP_MODE012 = 4'd6;
// Modes 4 and 5 restart at 0x5800
localparam logic [3:0] WRAP_MODE45  = 4'd11;

// Teletext screen sits at 0x3C00 or 0x7C00
localparam logic [3:0] TTX_FILL = 4'b1111;

endpackage

// File: rtl/sheila_regs.sv
`timescale 1ns/1ps

module sheila_regs (
	input  logic                     CLK32M_I,
	input  logic                     reset_n,
	input  logic                     model_i,
	input  logic                     cpu_clken_i,
	input  bbc_mem_pkg::cpu_addr_t   cpu_a_i,
	input  bbc_mem_pkg::cpu_data_t   cpu_do_i,
	input  logic                     cpu_r_nw_i,
	input  logic [3:0]               sys_via_pb_i,
	output bbc_mem_pkg::cpu_data_t   romsel_o,
	output bbc_mem_pkg::acccon_u     acccon_o,
	output logic [7:0]               ic32_o,
	output bbc_video_pkg::disp_offs_t disp_offs_o,
	output bbc_mem_pkg::cpu_data_t   regs_do_o,
	output logic                     regs_hit_o
);

import bbc_mem_pkg::*;

cpu_data_t  romsel_q;
acccon_u    acccon_q;
logic [7:0] ic32_q;

logic romsel_sel;
logic acccon_sel;
logic reg_wr;

assign romsel_sel = (cpu_a_i == ROMSEL_ADDR);
assign acccon_sel = (cpu_a_i == ACCCON_ADDR);
assign reg_wr     = cpu_clken_i & ~cpu_r_nw_i;

always_ff @(posedge CLK32M_I) begin
	if (!reset_n) begin
		romsel_q <= '0;
		acccon_q <= '0;
	end else begin
		if (reg_wr && romsel_sel) begin
			romsel_q <= cpu_do_i;
		end
		// Model B has no bit 7 in the ROM select latch
		if (!model_i) begin
			romsel_q[7] <= 1'b0;
		end
		if (reg_wr && acccon_sel) begin
			acccon_q.raw <= cpu_do_i;
		end
	end
end

// IC32 addressable latch, PB2..0 picks the bit and PB3 is its value
always_ff @(posedge CLK32M_I) begin
	if (!reset_n) begin
		ic32_q <= '0;
	end else begin
		ic32_q[sys_via_pb_i[2:0]] <= sys_via_pb_i[3];
	end
end

// Readback, ROM select only visible on the Master
always_comb begin
	regs_hit_o = 1'b0;
	regs_do_o  = '0;
	if (acccon_sel) begin
		regs_hit_o = 1'b1;
		regs_do_o  = acccon_q.raw;
	end else if (romsel_sel && model_i) begin
		regs_hit_o = 1'b1;
		regs_do_o  = romsel_q;
	end
end

assign romsel_o    = romsel_q;
assign acccon_o    = acccon_q;
assign ic32_o      = ic32_q;
// Screen wrap selector
assign disp_offs_o = ic32_q[5:4];

// Model B never holds bit 7 in the latch
romsel_b7_model_b: assert property (@(posedge CLK32M_I) disable iff (!reset_n)
	!model_i |-> !romsel_q[7]);

endmodule

// File: rtl/shadow_select.sv
`timescale 1ns/1ps

module shadow_select (
	input  logic                   CLK32M_I,
	input  logic                   reset_n,
	input  logic                   cpu_clken_i,
	input  bbc_mem_pkg::cpu_addr_t cpu_a_i,
	input  logic                   cpu_sync_i,
	input  bbc_mem_pkg::acccon_u   acccon_i,
	output logic                   shadow_ram_o
);

import bbc_mem_pkg::*;

// Last opcode fetch came from the VDU driver area
logic vdu_op_q;
logic in_window;
logic vdu_access;

always_ff @(posedge CLK32M_I) begin
	if (!reset_n) begin
		vdu_op_q <= 1'b0;
	end else if (cpu_clken_i && cpu_sync_i) begin
		vdu_op_q <= (cpu_a_i[15:13] == VDU_PAGE);
	end
end

assign in_window = (cpu_a_i[15:12] == SHADOW_LO_PAGE) ||
	(cpu_a_i[15:14] == SHADOW_HI_QUARTER);

// Data accesses made by VDU code, never the opcode fetch itself
assign vdu_access = acccon_i.flags.e & vdu_op_q & ~cpu_sync_i;

// X maps the whole window, E only for the VDU driver
assign shadow_ram_o = in_window & (acccon_i.flags.x | vdu_access);

endmodule

// File: rtl/display_addr.sv
`timescale 1ns/1ps

module display_addr (
	input  bbc_video_pkg::crtc_ma_t   crtc_ma_i,
	input  bbc_video_pkg::crtc_ra_t   crtc_ra_i,
	input  bbc_video_pkg::disp_offs_t disp_offs_i,
	output bbc_video_pkg::disp_addr_t disp_a_o
);

import bbc_video_pkg::*;

logic [3:0] wrap_offs;
logic [3:0] page;
disp_addr_t ttx_addr;
disp_addr_t hires_addr;

// Offset depends on how big the current screen is
always_comb begin
	case (disp_offs_i)
		2'b00: wrap_offs = WRAP_MODE3;
		2'b01: wrap_offs = WRAP_MODE6;
		2'b10: wrap_offs = WRAP_MODE012;
		2'b11: wrap_offs = WRAP_MODE45;
	endcase
end

// MA12 set means the CRTC has run past 0x8000
// Page add wraps modulo 16
assign page = crtc_ma_i[12] ? (crtc_ma_i[11:8] + wrap_offs) : crtc_ma_i[11:8];

// Teletext keeps a 1K screen, only page bit 3 picks the half
assign ttx_addr = {page[3], TTX_FILL, crtc_ma_i[9:0]};

// Bitmap modes step eight rows per character cell
assign hires_addr = {page, crtc_ma_i[7:0], crtc_ra_i};

assign disp_a_o = crtc_ma_i[13] ? ttx_addr : hires_addr;

endmodule

// File: rtl/bbc_mem_top.sv
`timescale 1ns/1ps

module bbc_mem_top (
	input  logic                     CLK32M_I,
	input  logic                     reset_n,
	input  logic                     model_i,
	input  logic                     cpu_clken_i,
	input  logic                     cpu_phi0_i,
	input  bbc_mem_pkg::cpu_addr_t   cpu_a_i,
	input  bbc_mem_pkg::cpu_data_t   cpu_do_i,
	input  logic                     cpu_r_nw_i,
	input  logic                     cpu_sync_i,
	input  logic [3:0]               sys_via_pb_i,
	input  bbc_video_pkg::crtc_ma_t  crtc_ma_i,
	input  bbc_video_pkg::crtc_ra_t  crtc_ra_i,
	output bbc_mem_pkg::cpu_addr_t   mem_adr_o,
	output logic                     mem_we_o,
	output bbc_mem_pkg::cpu_data_t   romsel_o,
	output bbc_mem_pkg::cpu_data_t   regs_do_o,
	output logic                     regs_hit_o,
	output logic [7:0]               ic32_o,
	output logic                     shadow_ram_o,
	output logic                     shadow_vid_o,
	output logic                     acc_y_o,
	output logic                     acc_irr_o
);

import bbc_mem_pkg::*;
import bbc_video_pkg::*;

acccon_u    acccon;
disp_offs_t disp_offs;
disp_addr_t disp_a;

sheila_regs u_sheila_regs (
	.CLK32M_I    (CLK32M_I),
	.reset_n     (reset_n),
	.model_i     (model_i),
	.cpu_clken_i (cpu_clken_i),
	.cpu_a_i     (cpu_a_i),
	.cpu_do_i    (cpu_do_i),
	.cpu_r_nw_i  (cpu_r_nw_i),
	.sys_via_pb_i(sys_via_pb_i),
	.romsel_o    (romsel_o),
	.acccon_o    (acccon),
	.ic32_o      (ic32_o),
	.disp_offs_o (disp_offs),
	.regs_do_o   (regs_do_o),
	.regs_hit_o  (regs_hit_o)
);

shadow_select u_shadow_select (
	.CLK32M_I    (CLK32M_I),
	.reset_n     (reset_n),
	.cpu_clken_i (cpu_clken_i),
	.cpu_a_i     (cpu_a_i),
	.cpu_sync_i  (cpu_sync_i),
	.acccon_i    (acccon),
	.shadow_ram_o(shadow_ram_o)
);

display_addr u_display_addr (
	.crtc_ma_i  (crtc_ma_i),
	.crtc_ra_i  (crtc_ra_i),
	.disp_offs_i(disp_offs),
	.disp_a_o   (disp_a)
);

// CPU owns the RAM during PHI0, video fetches in the other half
assign mem_adr_o = cpu_phi0_i ? cpu_a_i : {1'b0, disp_a};
assign mem_we_o  = cpu_phi0_i & ~cpu_r_nw_i;

assign shadow_vid_o = acccon.flags.d;
assign acc_y_o      = acccon.flags.y;
assign acc_irr_o    = acccon.flags.irr;

// Teletext fetches land in the top 1K of the lower 32K
ttx_fetch_addr: assert property (@(posedge CLK32M_I) disable iff (!reset_n)
	(!cpu_phi0_i && crtc_ma_i[13]) |->
	(mem_adr_o[15] == 1'b0 && mem_adr_o[13:10] == TTX_FILL));

endmodule

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running totals over the whole run
int checks_run    = 0;
int checks_failed = 0;

// Random source state
logic [7:0] lfsr_state = 8'd38;

// 8-bit Fibonacci LFSR with taps 8, 6, 5 and 4
function automatic logic [7:0] lfsr_next(input logic [7:0] s);
	logic fb;
	fb = s[7] ^ s[5] ^ s[4] ^ s[3];
	return {s[6:0], fb};
endfunction

// One LFSR step for every bit taken
task automatic random_bits(input int count, output logic [15:0] value);
	value = '0;
	for (int i = 0; i < count; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		value = {value[14:0], lfsr_state[0]};
	end
endtask

task automatic check_data(input cpu_data_t got, input cpu_data_t exp, input string msg);
	checks_run++;
	if (got !== exp) begin
		checks_failed++;
		$display("FAIL t=%0t %s: got %h expected %h", $time, msg, got, exp);
	end
endtask

task automatic check_addr(input cpu_addr_t got, input cpu_addr_t exp, input string msg);
	checks_run++;
	if (got !== exp) begin
		checks_failed++;
		$display("FAIL t=%0t %s: got %h expected %h", $time, msg, got, exp);
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string msg);
	checks_run++;
	if (got !== exp) begin
		checks_failed++;
		$display("FAIL t=%0t %s: got %b expected %b", $time, msg, got, exp);
	end
endtask

// One line per finished test
task automatic report_test(input string name, input int fails_before);
	if (checks_failed == fails_before)
		$display("%s: ok", name);
	else
		$display("%s: %0d mismatches", name, checks_failed - fails_before);
endtask

`endif

// File: verification/tb_bbc_mem.sv
`timescale 1ns/1ps

module tb_bbc_mem;

import bbc_mem_pkg::*;
import bbc_video_pkg::*;

`include "tb_checks.svh"

// Upper bounds per test in clock cycles
localparam int RESET_CYCLES   = 4;
localparam int ROMSEL_CYCLES  = 12;
localparam int ACCCON_CYCLES  = 52;
localparam int IC32_CYCLES    = 34;
localparam int SHADOW_CYCLES  = 28;
localparam int DISPLAY_CYCLES = 62;
localparam int CYCLE_LIMIT    = RESET_CYCLES + ROMSEL_CYCLES + ACCCON_CYCLES +
	IC32_CYCLES + SHADOW_CYCLES + DISPLAY_CYCLES + 50;

logic       clk32m;
logic       reset_n;
logic       model;
logic       cpu_clken;
logic       cpu_phi0;
cpu_addr_t  cpu_a;
cpu_data_t  cpu_do;
logic       cpu_r_nw;
logic       cpu_sync;
logic [3:0] sys_via_pb;
crtc_ma_t   crtc_ma;
crtc_ra_t   crtc_ra;
cpu_addr_t  mem_adr;
logic       mem_we;
cpu_data_t  romsel;
cpu_data_t  regs_do;
logic       regs_hit;
logic [7:0] ic32;
logic       shadow_ram;
logic       shadow_vid;
logic       acc_y;
logic       acc_irr;
int         cycle_count = 0;

bbc_mem_top u_dut (
	.CLK32M_I    (clk32m),
	.reset_n     (reset_n),
	.model_i     (model),
	.cpu_clken_i (cpu_clken),
	.cpu_phi0_i  (cpu_phi0),
	.cpu_a_i     (cpu_a),
	.cpu_do_i    (cpu_do),
	.cpu_r_nw_i  (cpu_r_nw),
	.cpu_sync_i  (cpu_sync),
	.sys_via_pb_i(sys_via_pb),
	.crtc_ma_i   (crtc_ma),
	.crtc_ra_i   (crtc_ra),
	.mem_adr_o   (mem_adr),
	.mem_we_o    (mem_we),
	.romsel_o    (romsel),
	.regs_do_o   (regs_do),
	.regs_hit_o  (regs_hit),
	.ic32_o      (ic32),
	.shadow_ram_o(shadow_ram),
	.shadow_vid_o(shadow_vid),
	.acc_y_o     (acc_y),
	.acc_irr_o   (acc_irr)
);

initial begin
	clk32m = 1'b0;
	forever #20 clk32m = ~clk32m;
end

always @(posedge clk32m) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= CYCLE_LIMIT) begin
		$display("Checks failed");
		$display("Timeout: run passed %0d cycles without finishing", cycle_count);
		$finish;
	end
end

// Bus cycle, address stays on the bus afterwards for readback
task automatic bus_write(input cpu_addr_t addr, input cpu_data_t data, input logic en);
	@(posedge clk32m);
	cpu_a     <= addr;
	cpu_do    <= data;
	cpu_r_nw  <= 1'b0;
	cpu_clken <= en;
	@(posedge clk32m);
	cpu_clken <= 1'b0;
	cpu_r_nw  <= 1'b1;
	@(negedge clk32m);
endtask

// PB stays held, so the same bit keeps being rewritten
task automatic ic32_write(input logic value, input logic [2:0] sel);
	@(posedge clk32m);
	sys_via_pb <= {value, sel};
	@(posedge clk32m);
	@(negedge clk32m);
endtask

task automatic opcode_fetch(input cpu_addr_t addr);
	@(posedge clk32m);
	cpu_a     <= addr;
	cpu_sync  <= 1'b1;
	cpu_clken <= 1'b1;
	@(posedge clk32m);
	cpu_sync  <= 1'b0;
	cpu_clken <= 1'b0;
endtask

task automatic probe_shadow(input cpu_addr_t addr, input logic exp);
	@(posedge clk32m);
	cpu_a    <= addr;
	cpu_sync <= 1'b0;
	@(negedge clk32m);
	check_bit(shadow_ram, exp, $sformatf("shadow select at %h", addr));
endtask

// Page offsets 8, 12, 6, 11 for selectors 0 to 3
function automatic cpu_addr_t expected_video_addr(input crtc_ma_t ma, input crtc_ra_t ra,
	input disp_offs_t sel);
	logic [3:0] offs;
	logic [3:0] page;
	case (sel)
		2'd0: offs = 4'd8;
		2'd1: offs = 4'd12;
		2'd2: offs = 4'd6;
		default: offs = 4'd11;
	endcase
	page = ma[11:8];
	if (ma[12])
		page = page + offs;
	if (ma[13])
		return {1'b0, page[3], 4'hF, ma[9:0]};
	return {1'b0, page, ma[7:0], ra};
endfunction

task automatic test_after_reset();
	int fails;
	fails = checks_failed;
	@(negedge clk32m);
	check_data(romsel, 8'h00, "romsel after reset");
	check_data(ic32, 8'h00, "ic32 after reset");
	check_bit(acc_y, 1'b0, "acc_y after reset");
	check_bit(acc_irr, 1'b0, "acc_irr after reset");
	check_bit(shadow_vid, 1'b0, "shadow_vid after reset");
	check_bit(shadow_ram, 1'b0, "shadow_ram after reset");
	report_test("after_reset", fails);
endtask

task automatic test_romsel();
	int fails;
	fails = checks_failed;
	bus_write(ROMSEL_ADDR, 8'h8F, 1'b1);
	check_data(romsel, 8'h0F, "romsel on model B");
	check_bit(regs_hit, 1'b0, "romsel readback hit on model B");
	@(posedge clk32m);
	model <= 1'b1;
	bus_write(ROMSEL_ADDR, 8'h8F, 1'b1);
	check_data(romsel, 8'h8F, "romsel on Master");
	check_bit(regs_hit, 1'b1, "romsel readback hit on Master");
	check_data(regs_do, 8'h8F, "romsel readback on Master");
	bus_write(ROMSEL_ADDR, 8'h12, 1'b0);
	check_data(romsel, 8'h8F, "romsel after write without clock enable");
	report_test("romsel", fails);
endtask

task automatic test_acccon();
	int fails;
	logic [15:0] v;
	fails = checks_failed;
	for (int i = 0; i < 16; i++) begin
		random_bits(8, v);
		bus_write(ACCCON_ADDR, v[7:0], 1'b1);
		check_bit(regs_hit, 1'b1, "acccon readback hit");
		check_data(regs_do, v[7:0], "acccon readback");
		check_bit(acc_irr, v[7], "acc_irr flag");
		check_bit(acc_y, v[3], "acc_y flag");
		check_bit(shadow_vid, v[0], "shadow_vid flag");
	end
	bus_write(ACCCON_ADDR, 8'h00, 1'b1);
	report_test("acccon", fails);
endtask

task automatic test_ic32();
	int fails;
	logic [7:0] exp;
	fails = checks_failed;
	exp = 8'h00;
	// Set all eight bits in turn, then clear them again
	for (int i = 0; i < 16; i++) begin
		exp[i % 8] = (i < 8);
		ic32_write(i < 8, 3'(i % 8));
		check_data(ic32, exp, $sformatf("ic32 step %0d", i));
	end
	report_test("ic32", fails);
endtask

task automatic test_shadow();
	int fails;
	fails = checks_failed;
	bus_write(ACCCON_ADDR, 8'h04, 1'b1);
	probe_shadow(16'h3000, 1'b1);
	probe_shadow(16'h5FFF, 1'b1);
	probe_shadow(16'h7FFF, 1'b1);
	probe_shadow(16'h2FFF, 1'b0);
	probe_shadow(16'h8000, 1'b0);
	// Only E, so the last fetch address decides
	bus_write(ACCCON_ADDR, 8'h02, 1'b1);
	opcode_fetch(16'hC100);
	probe_shadow(16'h4000, 1'b1);
	opcode_fetch(16'hE000);
	probe_shadow(16'h4000, 1'b0);
	bus_write(ACCCON_ADDR, 8'h00, 1'b1);
	report_test("shadow", fails);
endtask

task automatic test_display();
	int fails;
	logic [15:0] v;
	logic [15:0] w;
	fails = checks_failed;
	for (int s = 0; s < 4; s++) begin
		ic32_write(s[0], 3'd4);
		ic32_write(s[1], 3'd5);
		for (int i = 0; i < 8; i++) begin
			random_bits(14, v);
			random_bits(3, w);
			// Half the samples take the wrap path
			v[12] = i[0];
			@(posedge clk32m);
			crtc_ma <= v[13:0];
			crtc_ra <= w[2:0];
			@(negedge clk32m);
			check_addr(mem_adr, expected_video_addr(v[13:0], w[2:0], 2'(s)),
				$sformatf("video address sel %0d", s));
		end
	end
	for (int i = 0; i < 6; i++) begin
		random_bits(16, v);
		random_bits(1, w);
		@(posedge clk32m);
		cpu_phi0 <= 1'b1;
		cpu_a    <= v;
		cpu_r_nw <= w[0];
		@(negedge clk32m);
		check_addr(mem_adr, v, "cpu address during phi0");
		check_bit(mem_we, ~w[0], "write enable during phi0");
	end
	@(posedge clk32m);
	cpu_phi0 <= 1'b0;
	cpu_r_nw <= 1'b1;
	report_test("display", fails);
endtask

initial begin
	reset_n    = 1'b0;
	model      = 1'b0;
	cpu_clken  = 1'b0;
	cpu_phi0   = 1'b0;
	cpu_a      = '0;
	cpu_do     = '0;
	cpu_r_nw   = 1'b1;
	cpu_sync   = 1'b0;
	sys_via_pb = 4'h0;
	crtc_ma    = '0;
	crtc_ra    = '0;
	repeat (2) @(posedge clk32m);
	reset_n <= 1'b1;
	test_after_reset();
	test_romsel();
	test_acccon();
	test_ic32();
	test_shadow();
	test_display();
	$display("Summary: %0d compares, %0d mismatches", checks_run, checks_failed);
	if (checks_failed == 0) begin
		$display("All checks passed");
	end else begin
		$display("Checks failed");
	end
	$finish;
end

endmodule

// File: compile.f
+incdir+include
rtl/bbc_mem_pkg.sv
rtl/bbc_video_pkg.sv
rtl/sheila_regs.sv
rtl/shadow_select.sv
rtl/display_addr.sv
rtl/bbc_mem_top.sv
verification/tb_bbc_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_bbc_mem

if ! verilator --binary --timing --assert -f compile.f \
	--top-module "$TOP" --Mdir obj_dir -o "V$TOP"; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL: see $LOG"
exit 1
